/* hdl/rx_pkg.sv */
`default_nettype none

package rx_pkg;

    typedef logic [9:0]  symbol_t;   // line symbol, first bit in bit 9
    typedef logic [7:0]  byte_t;
    typedef logic [23:0] word_t;     // first byte in 23:16
    typedef logic [7:0]  cnt_t;

    // error and lost counters stop here
    localparam cnt_t CNT_MAX = 8'd255;

    // bus register map, word addresses
    typedef enum logic [2:0] {
        REG_CTRL   = 3'd0,  // bit 0 enable, bit 1 invert
        REG_STATUS = 3'd1,  // bit 0 empty, bit 1 overflow, bit 2 full
        REG_COUNTS = 3'd2,  // error count 7:0, lost count 15:8
        REG_LEVEL  = 3'd3,  // fifo fill count
        REG_DATA   = 3'd4   // head word, read pops
    } reg_addr_e;

endpackage

`default_nettype wire

/* hdl/dec_byte_if.sv */
`timescale 1ns/1ps
`default_nettype none

// decoded bytes, one per valid cycle, link cannot stall
interface dec_byte_if import rx_pkg::*; ();

    logic  valid;
    logic  k;       // control character
    byte_t data;
    logic  err;     // code or disparity error

    modport src (output valid, k, data, err);
    modport snk (input valid, k, data, err);

endinterface

`default_nettype wire

/* hdl/symbol_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module symbol_decoder import rx_pkg::*; (
    input  logic    WCLK,
    input  logic    RESET_WCLK,
    input  symbol_t symbol,
    input  logic    symbol_valid,
    input  logic    enable,
    input  logic    invert,
    dec_byte_if.src out
);

    // 5b/6b sub-block in abcdei order, returns {valid, EDCBA}
    function automatic logic [5:0] dec6(input logic [5:0] c);
        logic [5:0] r;
        r = 6'b100000;
        case (c)
            6'b100111, 6'b011000: r[4:0] = 5'd0;
            6'b011101, 6'b100010: r[4:0] = 5'd1;
            6'b101101, 6'b010010: r[4:0] = 5'd2;
            6'b110001:            r[4:0] = 5'd3;
            6'b110101, 6'b001010: r[4:0] = 5'd4;
            6'b101001:            r[4:0] = 5'd5;
            6'b011001:            r[4:0] = 5'd6;
            6'b111000, 6'b000111: r[4:0] = 5'd7;
            6'b111001, 6'b000110: r[4:0] = 5'd8;
            6'b100101:            r[4:0] = 5'd9;
            6'b010101:            r[4:0] = 5'd10;
            6'b110100:            r[4:0] = 5'd11;
            6'b001101:            r[4:0] = 5'd12;
            6'b101100:            r[4:0] = 5'd13;
            6'b011100:            r[4:0] = 5'd14;
            6'b010111, 6'b101000: r[4:0] = 5'd15;
            6'b011011, 6'b100100: r[4:0] = 5'd16;
            6'b100011:            r[4:0] = 5'd17;
            6'b010011:            r[4:0] = 5'd18;
            6'b110010:            r[4:0] = 5'd19;
            6'b001011:            r[4:0] = 5'd20;
            6'b101010:            r[4:0] = 5'd21;
            6'b011010:            r[4:0] = 5'd22;
            6'b111010, 6'b000101: r[4:0] = 5'd23;
            6'b110011, 6'b001100: r[4:0] = 5'd24;
            6'b100110:            r[4:0] = 5'd25;
            6'b010110:            r[4:0] = 5'd26;
            6'b110110, 6'b001001: r[4:0] = 5'd27;
            6'b001110, 6'b001111, 6'b110000: r[4:0] = 5'd28;  // D.28 and K.28
            6'b101110, 6'b010001: r[4:0] = 5'd29;
            6'b011110, 6'b100001: r[4:0] = 5'd30;
            6'b101011, 6'b010100: r[4:0] = 5'd31;
            default:              r = 6'b000000;  // 111100, 000011 and unbalanced
        endcase
        return r;
    endfunction

    // 3b/4b sub-block in fghj order, returns {valid, HGF}
    function automatic logic [3:0] dec4(input logic [3:0] c);
        logic [3:0] r;
        r = 4'b1000;
        case (c)
            4'b1011, 4'b0100: r[2:0] = 3'd0;
            4'b1001:          r[2:0] = 3'd1;
            4'b0101:          r[2:0] = 3'd2;
            4'b1100, 4'b0011: r[2:0] = 3'd3;
            4'b1101, 4'b0010: r[2:0] = 3'd4;
            4'b1010:          r[2:0] = 3'd5;
            4'b0110:          r[2:0] = 3'd6;
            4'b1110, 4'b0001, 4'b0111, 4'b1000: r[2:0] = 3'd7;  // primary and alternate
            default:          r = 4'b0000;
        endcase
        return r;
    endfunction

    symbol_t    sym_in;
    logic [9:0] code;       // bit a in 0, bit j in 9
    logic [5:0] sb6;        // abcdei, a in msb as the tables are written
    logic [3:0] sb4;        // fghj
    logic [5:0] r6;
    logic [3:0] r4;
    int         ones6;
    int         ones4;
    logic       k28;
    logic       kx7;
    logic       rd;         // running disparity, 1 = positive
    logic       rd6;        // disparity between the sub-blocks
    logic       rd_next;
    logic       code_err;
    logic       disp_err;
    logic       accept;

    assign sym_in = invert ? ~symbol : symbol;
    assign accept = symbol_valid && enable;

    always_comb begin
        for (int i = 0; i < 10; i++) begin
            code[i] = sym_in[9 - i];  // first received bit becomes a
        end
    end

    assign sb6   = {code[0], code[1], code[2], code[3], code[4], code[5]};
    assign sb4   = {code[6], code[7], code[8], code[9]};
    assign ones6 = $countones(sb6);
    assign ones4 = $countones(sb4);
    assign r6    = dec6(sb6);
    // K.28 at RD+ uses the complemented neutral 4b codes
    assign r4    = dec4((sb6 == 6'b110000) ? ~sb4 : sb4);

    assign k28 = (sb6 == 6'b001111) || (sb6 == 6'b110000);
    assign kx7 = (sb4 == 4'b0111 || sb4 == 4'b1000)
              && (r6[4:0] inside {5'd23, 5'd27, 5'd29, 5'd30});  // K.23/27/29/30.7

    assign rd6     = (ones6 == 4) ? 1'b1 : (ones6 == 2) ? 1'b0 : rd;
    assign rd_next = (ones4 == 3) ? 1'b1 : (ones4 == 1) ? 1'b0 : rd6;

    assign code_err = !r6[5] || !r4[3];
    // unbalanced blocks must flip the disparity, D.x.7 / D.x.3 neutrals pick a side
    assign disp_err = (ones6 == 4 && rd) || (ones6 == 2 && !rd)
                   || (sb6 == 6'b111000 && rd) || (sb6 == 6'b000111 && !rd)
                   || (ones4 == 3 && rd6) || (ones4 == 1 && !rd6)
                   || (sb4 == 4'b1100 && rd6) || (sb4 == 4'b0011 && !rd6);

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            rd        <= 1'b0;   // start at RD-
            out.valid <= 1'b0;
        end else begin
            out.valid <= accept;
            if (accept) begin
                rd <= rd_next;
            end
        end
    end

    always_ff @(posedge WCLK) begin
        if (accept) begin
            out.data <= {r4[2:0], r6[4:0]};  // HGF EDCBA
            out.k    <= k28 || kx7;
            out.err  <= code_err || disp_err;
        end
    end

    // valid is the assembler's only qualifier
    a_valid_known: assert property (@(posedge WCLK) disable iff (RESET_WCLK)
        !$isunknown(out.valid));

endmodule

`default_nettype wire

/* hdl/word_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module word_assembler import rx_pkg::*; (
    input  logic    WCLK,
    input  logic    RESET_WCLK,
    dec_byte_if.snk in,
    input  logic    enable,
    input  logic    fifo_full,
    output logic    fifo_write,
    output word_t   fifo_word,
    output cnt_t    err_count,
    output cnt_t    lost_count,
    output logic    overflow
);

    logic [1:0] byte_idx;   // data bytes held so far
    byte_t      slot0;
    byte_t      slot1;
    logic       accept;
    logic       data_byte;
    logic       word_done;  // third data byte arriving

    assign accept    = in.valid && enable;
    assign data_byte = accept && !in.k;
    assign word_done = data_byte && (byte_idx == 2'd2);

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK || !enable) begin
            byte_idx <= 2'd0;
        end else if (accept) begin
            // K restarts packing
            if (in.k || byte_idx == 2'd2) begin
                byte_idx <= 2'd0;
            end else begin
                byte_idx <= byte_idx + 2'd1;
            end
        end
    end

    always_ff @(posedge WCLK) begin
        if (data_byte && byte_idx == 2'd0) begin
            slot0 <= in.data;
        end
        if (data_byte && byte_idx == 2'd1) begin
            slot1 <= in.data;
        end
        if (word_done) begin
            fifo_word <= {slot0, slot1, in.data};  // first byte on top
        end
    end

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            fifo_write <= 1'b0;
            lost_count <= '0;
            overflow   <= 1'b0;
        end else begin
            fifo_write <= word_done && !fifo_full;
            if (word_done && fifo_full) begin
                overflow <= 1'b1;  // sticky until a word gets in
                if (lost_count != CNT_MAX) begin
                    lost_count <= lost_count + 8'd1;
                end
            end else if (word_done) begin
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            err_count <= '0;
        end else if (accept && in.err && err_count != CNT_MAX) begin
            err_count <= err_count + 8'd1;
        end
    end

    // full is sampled a cycle ahead of the write; words are three bytes apart,
    // so the fifo cannot have filled in between
    a_no_write_full: assert property (@(posedge WCLK) disable iff (RESET_WCLK)
        fifo_write |-> !fifo_full);

endmodule

`default_nettype wire

/* hdl/word_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module word_fifo import rx_pkg::*; #(
    parameter int FIFO_AW = 4
) (
    input  logic             WCLK,
    input  logic             RESET_WCLK,
    input  logic             write,
    input  word_t            wdata,
    input  logic             pop,
    output word_t            head,
    output logic             empty,
    output logic             full,
    output logic [FIFO_AW:0] level
);

    localparam int DEPTH = 2 ** FIFO_AW;

    word_t              mem [DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               do_wr;
    logic               do_rd;

    assign do_wr = write && !full;
    assign do_rd = pop && !empty;
    assign empty = (count == '0);
    assign full  = count[FIFO_AW];  // only set at DEPTH
    assign head  = mem[rd_ptr];     // show-ahead
    assign level = count;

    always_ff @(posedge WCLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_pop_empty: assert property (@(posedge WCLK) disable iff (RESET_WCLK)
        pop |-> !empty);
    a_no_write_full: assert property (@(posedge WCLK) disable iff (RESET_WCLK)
        write |-> !full);

endmodule

`default_nettype wire

/* hdl/rx_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_wb_regs import rx_pkg::*; #(
    parameter int FIFO_AW = 4
) (
    input  logic             WCLK,
    input  logic             RESET_WCLK,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  logic [2:0]       wb_adr,
    input  logic [31:0]      wb_wdata,
    output logic [31:0]      wb_rdata,
    output logic             wb_ack,
    output logic             enable,
    output logic             invert,
    input  word_t            head,
    input  logic             empty,
    input  logic             full,
    input  logic [FIFO_AW:0] level,
    input  cnt_t             err_count,
    input  cnt_t             lost_count,
    input  logic             overflow,
    output logic             pop
);

    reg_addr_e   addr;
    logic        req;        // new cycle, not acked yet
    logic        pop_armed;  // acked read takes the head word
    logic [31:0] rd_mux;

    assign addr = reg_addr_e'(wb_adr);
    assign req  = wb_cyc && wb_stb && !wb_ack;
    assign pop  = wb_ack && pop_armed;

    always_comb begin
        rd_mux = '0;
        case (addr)
            REG_CTRL:   rd_mux[1:0]       = {invert, enable};
            REG_STATUS: rd_mux[2:0]       = {full, overflow, empty};
            REG_COUNTS: rd_mux[15:0]      = {lost_count, err_count};
            REG_LEVEL:  rd_mux[FIFO_AW:0] = level;
            REG_DATA:   rd_mux[23:0]      = empty ? '0 : head;
            default:    rd_mux            = '0;
        endcase
    end

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            wb_ack    <= 1'b0;
            pop_armed <= 1'b0;
            enable    <= 1'b0;   // nothing received until software says so
            invert    <= 1'b0;
        end else begin
            wb_ack    <= req;    // one cycle, then drops
            pop_armed <= req && !wb_we && addr == REG_DATA && !empty;
            if (req && wb_we && addr == REG_CTRL) begin
                enable <= wb_wdata[0];
                invert <= wb_wdata[1];
            end
        end
    end

    // captured with the request, held through the ack cycle
    always_ff @(posedge WCLK) begin
        if (req) begin
            wb_rdata <= rd_mux;
        end
    end

    // master must hold the request until it sees ack
    a_ack_in_cycle: assert property (@(posedge WCLK) disable iff (RESET_WCLK)
        wb_ack |-> wb_cyc && wb_stb);

endmodule

`default_nettype wire

/* hdl/rx_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_link_top import rx_pkg::*; #(
    parameter int FIFO_AW = 4   // 16 words
) (
    input  logic        WCLK,
    input  logic        RESET_WCLK,
    input  symbol_t     symbol,
    input  logic        symbol_valid,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [31:0] wb_wdata,
    output logic [31:0] wb_rdata,
    output logic        wb_ack
);

    dec_byte_if dec_byte ();

    logic             enable;
    logic             invert;
    logic             fifo_write;
    word_t            fifo_word;
    logic             fifo_pop;
    word_t            fifo_head;
    logic             fifo_empty;
    logic             fifo_full;
    logic [FIFO_AW:0] fifo_level;
    cnt_t             err_count;
    cnt_t             lost_count;
    logic             overflow;

    // decode
    symbol_decoder u_decoder (
        .WCLK(WCLK), .RESET_WCLK(RESET_WCLK),
        .symbol(symbol), .symbol_valid(symbol_valid),
        .enable(enable), .invert(invert),
        .out(dec_byte)
    );

    // execute
    word_assembler u_assembler (
        .WCLK(WCLK), .RESET_WCLK(RESET_WCLK),
        .in(dec_byte), .enable(enable),
        .fifo_full(fifo_full), .fifo_write(fifo_write), .fifo_word(fifo_word),
        .err_count(err_count), .lost_count(lost_count), .overflow(overflow)
    );

    // result
    word_fifo #(.FIFO_AW(FIFO_AW)) u_fifo (
        .WCLK(WCLK), .RESET_WCLK(RESET_WCLK),
        .write(fifo_write), .wdata(fifo_word), .pop(fifo_pop),
        .head(fifo_head), .empty(fifo_empty), .full(fifo_full), .level(fifo_level)
    );

    rx_wb_regs #(.FIFO_AW(FIFO_AW)) u_regs (
        .WCLK(WCLK), .RESET_WCLK(RESET_WCLK),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_wdata(wb_wdata),
        .wb_rdata(wb_rdata), .wb_ack(wb_ack),
        .enable(enable), .invert(invert),
        .head(fifo_head), .empty(fifo_empty), .full(fifo_full), .level(fifo_level),
        .err_count(err_count), .lost_count(lost_count), .overflow(overflow),
        .pop(fifo_pop)
    );

endmodule

`default_nettype wire

/* verif/tb_rx_link_tasks.svh */
`ifndef TB_RX_LINK_TASKS_SVH
`define TB_RX_LINK_TASKS_SVH

    // 5b/6b codes in abcdei order, RD- column, indexed by EDCBA
    localparam logic [5:0] CODE6_NEG [32] = '{
        6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
    };
    // 3b/4b codes in fghj order, RD- column, primary D.x.7
    localparam logic [3:0] CODE4_NEG [8] = '{
        4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
    };
    localparam symbol_t K28_5_NEG  = 10'b001111_1010;
    localparam symbol_t BAD_SYMBOL = 10'b110001_1111;  // D.3 6b, no 4b code is all ones

    // returns {rd after, symbol}, a in bit 9
    function automatic logic [10:0] encode_8b10b(input byte_t b, input logic is_k,
                                                 input logic rd);
        logic [4:0] x;
        logic [2:0] y;
        logic [5:0] c6;
        logic [3:0] c4;
        logic       rd6;
        logic       alt7;
        if (is_k) begin
            return rd ? {1'b0, ~K28_5_NEG} : {1'b1, K28_5_NEG};  // only K28.5 is sent
        end
        x  = b[4:0];
        y  = b[7:5];
        c6 = CODE6_NEG[x];
        // unbalanced blocks and the D.7 neutral take the other column at RD+
        if (rd && ($countones(c6) != 3 || x == 5'd7)) begin
            c6 = ~c6;
        end
        rd6  = ($countones(c6) == 3) ? rd : !rd;
        alt7 = (!rd6 && x inside {5'd17, 5'd18, 5'd20})
            || (rd6 && x inside {5'd11, 5'd13, 5'd14});  // avoids a run of five
        c4 = (y == 3'd7 && alt7) ? 4'b0111 : CODE4_NEG[y];
        if (rd6 && ($countones(c4) != 2 || y == 3'd3)) begin
            c4 = ~c4;
        end
        return {($countones(c4) == 2) ? rd6 : !rd6, c6, c4};
    endfunction

    // galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_byte(output byte_t b);
        for (int i = 0; i < 8; i++) begin
            b[i]       = lfsr_state[0];  // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // called at a falling edge, consecutive calls keep the strobe high
    task automatic send_symbol(input symbol_t s);
        symbol       = line_inverted ? ~s : s;
        symbol_valid = 1'b1;
        @(negedge WCLK);
        symbol_valid = 1'b0;
    endtask

    task automatic send_encoded(input byte_t b, input logic is_k);
        logic [10:0] enc;
        enc = encode_8b10b(b, is_k, run_disp);
        if (link_enabled) begin
            run_disp = enc[10];  // decoder ignores symbols while disabled
        end
        send_symbol(enc[9:0]);
    endtask

    task automatic send_comma();
        send_encoded(8'hbc, 1'b1);
    endtask

    task automatic send_random_bytes(input int n);
        byte_t b;
        repeat (n) begin
            random_byte(b);
            send_encoded(b, 1'b0);
        end
    endtask

    // three data bytes, first one ends up in 23:16
    task automatic send_random_word(input logic stored);
        byte_t b;
        word_t w;
        w = '0;
        repeat (3) begin
            random_byte(b);
            send_encoded(b, 1'b0);
            w = {w[15:0], b};
        end
        if (stored) begin
            expected_words.push_back(w);
        end
    endtask

    task automatic pop_and_check();
        logic [31:0] got;
        word_t       exp;
        exp = expected_words.pop_front();
        read_register(REG_DATA, got);
        check_value("wb_rdata REG_DATA", {8'h00, exp}, got);
    endtask

    task automatic drain_and_check();
        while (expected_words.size() > 0) begin
            pop_and_check();
        end
        expect_register(REG_STATUS, 32'h1);
        expect_register(REG_LEVEL, 32'h0);
    endtask

    task automatic check_reset_defaults();
        expect_register(REG_CTRL, 32'h0);
        expect_register(REG_STATUS, 32'h1);  // empty, no overflow
        expect_register(REG_COUNTS, 32'h0);
        expect_register(REG_LEVEL, 32'h0);
        send_comma();
        send_random_bytes(6);
        repeat (6) @(negedge WCLK);
        expect_register(REG_LEVEL, 32'h0);
        expect_register(REG_STATUS, 32'h1);
        write_register(REG_CTRL, 32'h1);
        link_enabled = 1'b1;
        expect_register(REG_CTRL, 32'h1);
    endtask

    task automatic stream_words_in_order();
        send_comma();
        repeat (10) send_random_word(1'b1);
        wait_for_level(10);
        expect_register(REG_COUNTS, {16'd0, exp_lost, exp_err});
        drain_and_check();
    endtask

    task automatic resync_on_comma();
        send_comma();
        send_random_bytes(1);
        send_comma();            // drops the single byte
        send_random_word(1'b1);
        send_random_bytes(2);
        send_comma();            // drops two bytes
        send_random_word(1'b1);
        wait_for_level(2);
        drain_and_check();
    endtask

    task automatic count_code_errors();
        for (int i = 0; i < 2; i++) begin
            send_comma();
            send_random_word(1'b1);
            send_symbol(BAD_SYMBOL);
            send_comma();        // stray byte from the bad symbol goes away
            send_random_word(1'b1);
            exp_err = exp_err + 8'd1;
        end
        wait_for_level(4);
        expect_register(REG_COUNTS, {16'd0, exp_lost, exp_err});
        drain_and_check();
    endtask

    task automatic receive_inverted();
        write_register(REG_CTRL, 32'h3);
        line_inverted = 1'b1;
        expect_register(REG_CTRL, 32'h3);
        send_comma();
        repeat (3) send_random_word(1'b1);
        wait_for_level(3);
        expect_register(REG_COUNTS, {16'd0, exp_lost, exp_err});
        drain_and_check();
        write_register(REG_CTRL, 32'h1);
        line_inverted = 1'b0;
    endtask

    task automatic fill_past_full();
        send_comma();
        for (int i = 0; i < 20; i++) begin
            send_random_word(i < 16);  // last four find the fifo full
        end
        exp_lost = exp_lost + 8'd4;
        wait_for_level(16);
        expect_register(REG_STATUS, 32'h6);  // full and overflow
        expect_register(REG_COUNTS, {16'd0, exp_lost, exp_err});
        pop_and_check();
        send_random_word(1'b1);
        wait_for_level(16);
        expect_register(REG_STATUS, 32'h4);  // overflow gone, lost count stays
        expect_register(REG_COUNTS, {16'd0, exp_lost, exp_err});
        drain_and_check();
    endtask

`endif

/* verif/tb_rx_link.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rx_link import rx_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int ACK_WAIT_MAX   = 16;

    logic        WCLK;
    logic        RESET_WCLK;
    symbol_t     symbol;
    logic        symbol_valid;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_wdata;
    logic [31:0] wb_rdata;
    logic        wb_ack;

    int          checks;
    int          errors;
    int          cycle_count;
    logic        run_disp;        // encoder running disparity, 1 = positive
    logic        link_enabled;    // DUT decodes, so its disparity moves too
    logic        line_inverted;
    logic [31:0] lfsr_state;
    word_t       expected_words[$];
    cnt_t        exp_err;
    cnt_t        exp_lost;

    rx_link_top #(.FIFO_AW(4)) DUT (
        .WCLK(WCLK), .RESET_WCLK(RESET_WCLK),
        .symbol(symbol), .symbol_valid(symbol_valid),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_wdata(wb_wdata),
        .wb_rdata(wb_rdata), .wb_ack(wb_ack)
    );

    `include "tb_rx_link_tasks.svh"

    initial begin
        WCLK = 1'b0;
        forever #20 WCLK = ~WCLK;
    end

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error: %s expected %h got %h", what, exp, got);
        end
    endtask

    // request held through the ack cycle, ack and rdata sampled at the falling edge
    task automatic wishbone_access(input logic we, input reg_addr_e addr,
                                   input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_wdata = wdata;
        do begin
            @(negedge WCLK);
            waited++;
        end while (!wb_ack && waited < ACK_WAIT_MAX);
        assert (wb_ack) else begin
            errors++;
            $display("bus access to %s got no ack within %0d cycles", addr.name(),
                     ACK_WAIT_MAX);
        end
        rdata = wb_rdata;
        @(negedge WCLK);   // ack drops at the rising edge in between
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_register(input reg_addr_e addr, output logic [31:0] data);
        wishbone_access(1'b0, addr, 32'h0, data);
    endtask

    task automatic write_register(input reg_addr_e addr, input logic [31:0] data);
        logic [31:0] unused_rdata;
        wishbone_access(1'b1, addr, data, unused_rdata);
    endtask

    task automatic expect_register(input reg_addr_e addr, input logic [31:0] exp);
        logic [31:0] got;
        read_register(addr, got);
        check_value($sformatf("wb_rdata %s", addr.name()), exp, got);
    endtask

    // poll until the pipeline has delivered the words
    task automatic wait_for_level(input int exp_level);
        logic [31:0] level;
        int          polls;
        polls = 0;
        do begin
            read_register(REG_LEVEL, level);
            polls++;
        end while (level != exp_level && polls < 20);
        check_value("wb_rdata REG_LEVEL", exp_level, level);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge WCLK);
            cycle_count++;
        end
        $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        RESET_WCLK    = 1'b1;
        symbol        = '0;
        symbol_valid  = 1'b0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_wdata      = '0;
        checks        = 0;
        errors        = 0;
        run_disp      = 1'b0;    // DUT starts at RD- too
        link_enabled  = 1'b0;
        line_inverted = 1'b0;
        lfsr_state    = 32'h3ebd_fc3a;
        exp_err       = '0;
        exp_lost      = '0;
        repeat (5) @(negedge WCLK);
        RESET_WCLK = 1'b0;

        check_reset_defaults();
        stream_words_in_order();
        resync_on_comma();
        count_code_errors();
        receive_inverted();
        fill_past_full();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+verif
hdl/rx_pkg.sv
hdl/dec_byte_if.sv
hdl/symbol_decoder.sv
hdl/word_assembler.sv
hdl/word_fifo.sv
hdl/rx_wb_regs.sv
hdl/rx_link_top.sv
verif/tb_rx_link.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the rx link testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rx_link \
    -f sim.f \
    -o Vtb_rx_link

./obj_dir/Vtb_rx_link | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
